// ==== Makefile ====
# Verilator build for the block RAM subsystem

TOP := tb_bram_subsys

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f tb.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

// ==== common/bram_cfg.svh ====
// block RAM subsystem configuration
`ifndef BRAM_CFG_SVH
`define BRAM_CFG_SVH

// number of identical RAM banks
// one-hot selects are this wide
`define BANK_COUNT 4

// byte address width inside a single bank
// 12 bits give 4 KB per bank
`define BANK_ADDR_WIDTH 12

// width of one RAM line
// writes use one strobe per byte lane
`define DATA_WIDTH 128

// request byte address width
// bits above the bank field must be zero
`define ADDR_WIDTH 16

// resulting request address layout
//   [15:14] range check
//   [13:12] bank
//   [11:4]  line inside the bank
//   [3:0]   ignored, accesses are whole lines

`endif

// ==== common/bram_pkg.sv ====
// block RAM subsystem types
`default_nettype none

`include "bram_cfg.svh"

package bram_pkg;

   // byte offset bits inside one line
   localparam int LINE_OFFSET = $clog2(`DATA_WIDTH / 8);

   // width of the bank field in the address
   localparam int BANK_BITS = $clog2(`BANK_COUNT);

   // line index bits inside one bank
   localparam int LINE_WIDTH = `BANK_ADDR_WIDTH - LINE_OFFSET;
   localparam int LINE_COUNT = 2 ** LINE_WIDTH;

   // one RAM line
   typedef logic [`DATA_WIDTH-1:0] word_t;

   // byte write strobes
   typedef logic [`DATA_WIDTH/8-1:0] strb_t;

   // request byte address
   typedef logic [`ADDR_WIDTH-1:0] addr_t;

   // line inside a bank
   typedef logic [LINE_WIDTH-1:0] line_t;

   // one-hot bank select
   typedef logic [`BANK_COUNT-1:0] bank_sel_t;

endpackage

`default_nettype wire

// ==== ram_bank/ram_bank.sv ====
// byte-enabled RAM bank
`default_nettype none
`timescale 1ns/100ps

module ram_bank
   import bram_pkg::*;
(
   input  wire         mig_clk,

   // access strobes from the dispatcher
   input  wire         en_i,
   input  wire         we_i,
   input  wire line_t  line_i,
   input  wire word_t  wdata_i,
   input  wire strb_t  strb_i,

   // line at the captured address
   output word_t       rdata_o
);

   // line-addressed storage, inferred as block RAM
   word_t mem [LINE_COUNT];

   // registered read address
   line_t line_q;

   always_ff @(posedge mig_clk) begin
      if (en_i) begin
         line_q <= line_i;
         if (we_i) begin
            for (int i = 0; i < $bits(strb_t); i++) begin
               // only the strobed byte lanes change
               if (strb_i[i]) begin
                  mem[line_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
               end
            end
         end
      end
   end

   // a write at the capture edge is already visible here
   assign rdata_o = mem[line_q];

endmodule

`default_nettype wire

// ==== source/bank_dispatch.sv ====
// request address decode and dispatch
`default_nettype none
`timescale 1ns/100ps

`include "bram_cfg.svh"

module bank_dispatch
   import bram_pkg::*;
(
   input  wire            mig_clk,
   input  wire            rst_n_i,

   // request strobes
   input  wire            req_valid_i,
   input  wire            req_we_i,
   input  wire addr_t     req_addr_i,
   input  wire word_t     req_wdata_i,
   input  wire strb_t     req_strb_i,

   // registered bank access
   output bank_sel_t      bank_sel_o,
   output logic           bank_we_o,
   output line_t          bank_line_o,
   output word_t          bank_wdata_o,
   output strb_t          bank_strb_o,

   // response tracking
   output bank_sel_t      rd_sel_o,
   output logic           rd_err_o
);

   logic                  in_range;
   logic [BANK_BITS-1:0]  bank_idx;
   line_t                 line_idx;
   bank_sel_t             sel_dec;

   // range bits above the bank field must be clear
   assign in_range = (req_addr_i[`ADDR_WIDTH-1:`BANK_ADDR_WIDTH+BANK_BITS] == '0);

   assign bank_idx = req_addr_i[`BANK_ADDR_WIDTH +: BANK_BITS];
   assign line_idx = req_addr_i[LINE_OFFSET +: LINE_WIDTH];

   // one-hot bank strobe, only for a valid in-range request
   always_comb begin
      sel_dec = '0;
      if (req_valid_i && in_range) begin
         sel_dec[bank_idx] = 1'b1;
      end
   end

   always_ff @(posedge mig_clk) begin
      if (!rst_n_i) begin
         bank_sel_o <= '0;
         rd_sel_o   <= '0;
         rd_err_o   <= 1'b0;
      end else begin
         bank_sel_o <= sel_dec;
         // writes in range give no response
         rd_sel_o   <= req_we_i ? '0 : sel_dec;
         rd_err_o   <= req_valid_i && !in_range;
      end
   end

   // request fields, qualified downstream by bank_sel_o
   always_ff @(posedge mig_clk) begin
      if (req_valid_i) begin
         bank_we_o    <= req_we_i;
         bank_line_o  <= line_idx;
         bank_wdata_o <= req_wdata_i;
         bank_strb_o  <= req_strb_i;
      end
   end

endmodule

`default_nettype wire

// ==== source/bram_subsys_top.sv ====
// banked block RAM subsystem
`default_nettype none
`timescale 1ns/100ps

`include "bram_cfg.svh"

module bram_subsys_top
   import bram_pkg::*;
(
   input  wire         mig_clk,
   input  wire         rst_n_i,

   // request port
   input  wire         req_valid_i,
   input  wire         req_we_i,
   input  wire addr_t  req_addr_i,
   input  wire word_t  req_wdata_i,
   input  wire strb_t  req_strb_i,

   // response port
   output logic        resp_valid_o,
   output word_t       resp_rdata_o,
   output logic        resp_err_o
);

   // dispatcher to banks
   bank_sel_t  bank_sel;
   logic       bank_we;
   line_t      bank_line;
   word_t      bank_wdata;
   strb_t      bank_strb;

   // dispatcher to merger
   bank_sel_t  rd_sel;
   logic       rd_err;

   // banks to merger
   word_t      bank_rdata [`BANK_COUNT];

   bank_dispatch u_dispatch (
      .mig_clk      ( mig_clk      ),
      .rst_n_i      ( rst_n_i      ),
      .req_valid_i  ( req_valid_i  ),
      .req_we_i     ( req_we_i     ),
      .req_addr_i   ( req_addr_i   ),
      .req_wdata_i  ( req_wdata_i  ),
      .req_strb_i   ( req_strb_i   ),
      .bank_sel_o   ( bank_sel     ),
      .bank_we_o    ( bank_we      ),
      .bank_line_o  ( bank_line    ),
      .bank_wdata_o ( bank_wdata   ),
      .bank_strb_o  ( bank_strb    ),
      .rd_sel_o     ( rd_sel       ),
      .rd_err_o     ( rd_err       )
   );

   // each bank is enabled by its own select bit
   for (genvar g = 0; g < `BANK_COUNT; g++) begin : g_bank
      ram_bank u_bank (
         .mig_clk  ( mig_clk       ),
         .en_i     ( bank_sel[g]   ),
         .we_i     ( bank_we       ),
         .line_i   ( bank_line     ),
         .wdata_i  ( bank_wdata    ),
         .strb_i   ( bank_strb     ),
         .rdata_o  ( bank_rdata[g] )
      );
   end

   read_merge u_merge (
      .mig_clk       ( mig_clk      ),
      .rst_n_i       ( rst_n_i      ),
      .rd_sel_i      ( rd_sel       ),
      .rd_err_i      ( rd_err       ),
      .bank_rdata_i  ( bank_rdata   ),
      .resp_valid_o  ( resp_valid_o ),
      .resp_rdata_o  ( resp_rdata_o ),
      .resp_err_o    ( resp_err_o   )
   );

endmodule

`default_nettype wire

// ==== source/read_merge.sv ====
// read data merge and response register
`default_nettype none
`timescale 1ns/100ps

`include "bram_cfg.svh"

module read_merge
   import bram_pkg::*;
(
   input  wire            mig_clk,
   input  wire            rst_n_i,

   // response tracking from the dispatcher
   input  wire bank_sel_t rd_sel_i,
   input  wire            rd_err_i,

   // bank outputs
   input  wire word_t     bank_rdata_i [`BANK_COUNT],

   // response
   output logic           resp_valid_o,
   output word_t          resp_rdata_o,
   output logic           resp_err_o
);

   bank_sel_t  rd_sel_q;
   logic       rd_err_q;
   word_t      rdata_mux;

   // line up with bank read data
   always_ff @(posedge mig_clk) begin
      if (!rst_n_i) begin
         rd_sel_q <= '0;
         rd_err_q <= 1'b0;
      end else begin
         rd_sel_q <= rd_sel_i;
         rd_err_q <= rd_err_i;
      end
   end

   // one-hot select, so an OR of masked lines is enough
   always_comb begin
      rdata_mux = '0;
      for (int b = 0; b < `BANK_COUNT; b++) begin
         if (rd_sel_q[b]) begin
            rdata_mux = rdata_mux | bank_rdata_i[b];
         end
      end
   end

   always_ff @(posedge mig_clk) begin
      if (!rst_n_i) begin
         resp_valid_o <= 1'b0;
         resp_err_o   <= 1'b0;
      end else begin
         resp_valid_o <= (|rd_sel_q) || rd_err_q;
         resp_err_o   <= rd_err_q;
      end
   end

   // zero data on an error
   always_ff @(posedge mig_clk) begin
      resp_rdata_o <= rd_err_q ? '0 : rdata_mux;
   end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+common
common/bram_pkg.sv
ram_bank/ram_bank.sv
source/bank_dispatch.sv
source/read_merge.sv
source/bram_subsys_top.sv
testbench/bram_subsys_assertions.sv
testbench/tb_bram_subsys.sv

// ==== testbench/bram_subsys_assertions.sv ====
// block RAM subsystem assertions
`default_nettype none
`timescale 1ns/100ps

`include "bram_cfg.svh"

module bram_subsys_assertions
   import bram_pkg::*;
(
   input  wire            mig_clk,
   input  wire            rst_n_i,
   input  wire            req_valid_i,
   input  wire            req_we_i,
   input  wire addr_t     req_addr_i,
   input  wire bank_sel_t bank_sel_i,
   input  wire            resp_valid_i,
   input  wire            resp_err_i
);

   logic needs_resp;
   logic out_of_range;

   assign out_of_range = (req_addr_i[`ADDR_WIDTH-1:`BANK_ADDR_WIDTH+BANK_BITS] != '0);
   assign needs_resp   = req_valid_i && (!req_we_i || out_of_range);

   // response register updates at edge 2, seen here one edge later
   a_resp_timing : assert property (@(posedge mig_clk) disable iff (!rst_n_i)
      resp_valid_i == $past(needs_resp, 3))
      else $error("response valid does not match a request two cycles earlier");

   // at most one bank, the one named by the previous in-range request
   a_bank_select : assert property (@(posedge mig_clk) disable iff (!rst_n_i)
      bank_sel_i == ($past(req_valid_i && !out_of_range)
                     ? bank_sel_t'(1) << $past(req_addr_i[`BANK_ADDR_WIDTH +: BANK_BITS])
                     : '0))
      else $error("bank select does not match the previous request");

   // error pulse follows an out-of-range request and comes with valid
   a_err_valid : assert property (@(posedge mig_clk) disable iff (!rst_n_i)
      resp_err_i == $past(req_valid_i && out_of_range, 3) && (!resp_err_i || resp_valid_i))
      else $error("error flag without a matching out-of-range request");

endmodule

bind bram_subsys_top bram_subsys_assertions u_assertions (
   .mig_clk      ( mig_clk      ),
   .rst_n_i      ( rst_n_i      ),
   .req_valid_i  ( req_valid_i  ),
   .req_we_i     ( req_we_i     ),
   .req_addr_i   ( req_addr_i   ),
   .bank_sel_i   ( bank_sel     ),
   .resp_valid_i ( resp_valid_o ),
   .resp_err_i   ( resp_err_o   )
);

`default_nettype wire

// ==== testbench/tb_bram_subsys.sv ====
// block RAM subsystem testbench
`default_nettype none
`timescale 1ns/100ps

`include "bram_cfg.svh"

module tb_bram_subsys
   import bram_pkg::*;
;

   typedef struct {
      string  name;
      logic   we;
      addr_t  addr;
      word_t  wdata;
      strb_t  strb;
      word_t  exp_data;
      logic   exp_err;
   } row_t;

   typedef struct {
      string  name;
      logic   resp;
      word_t  data;
      logic   err;
      int     due;
   } exp_t;

   localparam word_t D0 = 128'h00112233_44556677_8899aabb_ccddeeff;
   localparam word_t D1 = 128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0;
   localparam word_t D2 = 128'hdeadbeef_01234567_89abcdef_fedcba98;
   localparam word_t D3 = 128'h13579bdf_2468ace0_fdb97531_0eca8642;
   localparam word_t D5 = 128'hcafef00d_5a5a5a5a_a5a5a5a5_0badc0de;
   localparam word_t ONES = '1;
   // D0 with its low eight bytes overwritten by 0xaa
   localparam word_t PART = 128'h00112233_44556677_aaaaaaaa_aaaaaaaa;

   logic   mig_clk;
   logic   rst_n_i;
   logic   req_valid_i;
   logic   req_we_i;
   addr_t  req_addr_i;
   word_t  req_wdata_i;
   strb_t  req_strb_i;
   logic   resp_valid_o;
   word_t  resp_rdata_o;
   logic   resp_err_o;

   row_t   stim_tab[$];
   exp_t   pend_q[$];
   word_t  model [`BANK_COUNT*4];
   int     cyc;
   int     tests;
   int     failed;
   int     errors;
   bit     test_fail;

   bram_subsys_top DUT (
      .mig_clk      ( mig_clk      ),
      .rst_n_i      ( rst_n_i      ),
      .req_valid_i  ( req_valid_i  ),
      .req_we_i     ( req_we_i     ),
      .req_addr_i   ( req_addr_i   ),
      .req_wdata_i  ( req_wdata_i  ),
      .req_strb_i   ( req_strb_i   ),
      .resp_valid_o ( resp_valid_o ),
      .resp_rdata_o ( resp_rdata_o ),
      .resp_err_o   ( resp_err_o   )
   );

   initial begin
      mig_clk = 1'b0;
      forever begin
         #5 mig_clk = ~mig_clk;
      end
   end

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("Fail %s: data expected %h, actual %h", name, exp, act);
         test_fail = 1'b1;
         errors++;
      end
   endtask

   task automatic check_err(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail %s: error flag expected %b, actual %b", name, exp, act);
         test_fail = 1'b1;
         errors++;
      end
   endtask

   task automatic check_valid(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail %s: response valid expected %b, actual %b", name, exp, act);
         test_fail = 1'b1;
         errors++;
      end
   endtask

   // compare the response slot of the request that is due now
   task automatic check_due();
      exp_t e;
      if (pend_q.size() != 0 && pend_q[0].due == cyc) begin
         e = pend_q.pop_front();
         test_fail = 1'b0;
         check_valid(e.name, e.resp, resp_valid_o);
         if (e.resp) begin
            check_err(e.name, e.err, resp_err_o);
            check_word(e.name, e.data, resp_rdata_o);
         end
         tests++;
         if (test_fail) begin
            failed++;
         end
         $display("%s: %s", e.name, test_fail ? "mismatch" : "ok");
      end else if (resp_valid_o) begin
         $display("response appeared at cycle %0d with no request due", cyc);
         errors++;
      end
   endtask

   task automatic advance_cycle();
      @(negedge mig_clk);
      cyc++;
      check_due();
   endtask

   task automatic idle_cycle();
      advance_cycle();
      req_valid_i = 1'b0;
      req_we_i    = 1'b0;
   endtask

   // response shows up three falling edges after the drive edge
   task automatic drive_request(input string name, input logic we, input addr_t addr,
                                input word_t wdata, input strb_t strb,
                                input word_t exp_data, input logic exp_err);
      exp_t e;
      advance_cycle();
      req_valid_i = 1'b1;
      req_we_i    = we;
      req_addr_i  = addr;
      req_wdata_i = wdata;
      req_strb_i  = strb;
      e.name = name;
      e.resp = !we || exp_err;
      e.data = exp_data;
      e.err  = exp_err;
      e.due  = cyc + 3;
      pend_q.push_back(e);
   endtask

   task automatic add_row(input string name, input logic we, input addr_t addr,
                          input word_t wdata, input strb_t strb,
                          input word_t exp_data, input logic exp_err);
      row_t r;
      r.name     = name;
      r.we       = we;
      r.addr     = addr;
      r.wdata    = wdata;
      r.strb     = strb;
      r.exp_data = exp_data;
      r.exp_err  = exp_err;
      stim_tab.push_back(r);
   endtask

   function automatic word_t merge_bytes(input word_t old, input word_t wdata, input strb_t strb);
      word_t res;
      res = old;
      for (int i = 0; i < $bits(strb_t); i++) begin
         if (strb[i]) begin
            res[i*8 +: 8] = wdata[i*8 +: 8];
         end
      end
      return res;
   endfunction

   function automatic addr_t make_addr(input logic [1:0] rng, input logic [1:0] bank,
                                       input line_t ln, input logic [3:0] low);
      return {rng, bank, ln, low};
   endfunction

   initial begin
      logic [1:0]   bank;
      logic [1:0]   rng;
      line_t        ln;
      logic         we;
      word_t        wd;
      strb_t        st;
      int           idx;
      string        nm;

      void'($urandom(32'h40aa3559));
      rst_n_i     = 1'b0;
      req_valid_i = 1'b0;
      req_we_i    = 1'b0;
      req_addr_i  = '0;
      req_wdata_i = '0;
      req_strb_i  = '0;
      cyc    = 0;
      tests  = 0;
      failed = 0;
      errors = 0;

      for (int i = 0; i < 8; i++) begin
         @(posedge mig_clk);
      end
      @(negedge mig_clk);
      rst_n_i = 1'b1;

      add_row("wr_bank0", 1'b1, 16'h0200, D0, 16'hffff, '0, 1'b0);
      add_row("wr_bank1", 1'b1, 16'h1200, D1, 16'hffff, '0, 1'b0);
      add_row("wr_bank2", 1'b1, 16'h2200, D2, 16'hffff, '0, 1'b0);
      add_row("wr_bank3", 1'b1, 16'h3200, D3, 16'hffff, '0, 1'b0);
      add_row("rd_bank0", 1'b0, 16'h0200, '0, '0, D0, 1'b0);
      add_row("rd_bank1", 1'b0, 16'h1208, '0, '0, D1, 1'b0);
      add_row("rd_bank2", 1'b0, 16'h2200, '0, '0, D2, 1'b0);
      add_row("rd_bank3", 1'b0, 16'h3200, '0, '0, D3, 1'b0);
      add_row("wr_partial", 1'b1, 16'h0200, {16{8'haa}}, 16'h00ff, '0, 1'b0);
      add_row("rd_partial", 1'b0, 16'h0200, '0, '0, PART, 1'b0);
      add_row("wr_then_rd_w", 1'b1, 16'h3210, D5, 16'hffff, '0, 1'b0);
      add_row("wr_then_rd_r", 1'b0, 16'h3210, '0, '0, D5, 1'b0);
      add_row("rd_oor", 1'b0, 16'h4200, '0, '0, '0, 1'b1);
      add_row("wr_oor", 1'b1, 16'h4200, ONES, 16'hffff, '0, 1'b1);
      add_row("rd_oor_hi", 1'b0, 16'h8000, '0, '0, '0, 1'b1);
      add_row("rd_after_oor", 1'b0, 16'h0200, '0, '0, PART, 1'b0);

      foreach (stim_tab[i]) begin
         drive_request(stim_tab[i].name, stim_tab[i].we, stim_tab[i].addr,
                       stim_tab[i].wdata, stim_tab[i].strb,
                       stim_tab[i].exp_data, stim_tab[i].exp_err);
      end

      // known contents for the lines the random phase touches
      for (int i = 0; i < `BANK_COUNT * 4; i++) begin
         wd = {$urandom, $urandom, $urandom, $urandom};
         model[i] = wd;
         drive_request($sformatf("prewrite_%0d", i), 1'b1,
                       make_addr(2'b00, 2'(i / 4), line_t'(i % 4), 4'h0),
                       wd, '1, '0, 1'b0);
      end

      for (int i = 0; i < 64; i++) begin
         bank = 2'($urandom_range(3));
         ln   = line_t'($urandom_range(3));
         rng  = ($urandom_range(7) == 0) ? 2'($urandom_range(3, 1)) : 2'b00;
         we   = 1'($urandom_range(1));
         wd   = {$urandom, $urandom, $urandom, $urandom};
         st   = strb_t'($urandom);
         idx  = int'(bank) * 4 + int'(ln);
         nm   = $sformatf("rand_%0d", i);
         if (rng != 2'b00) begin
            drive_request(nm, we, make_addr(rng, bank, ln, 4'($urandom)), wd, st, '0, 1'b1);
         end else if (we) begin
            model[idx] = merge_bytes(model[idx], wd, st);
            drive_request(nm, 1'b1, make_addr(rng, bank, ln, 4'h0), wd, st, '0, 1'b0);
         end else begin
            drive_request(nm, 1'b0, make_addr(rng, bank, ln, 4'h0), wd, st, model[idx], 1'b0);
         end
      end

      for (int w = 0; w < 20 && pend_q.size() != 0; w++) begin
         idle_cycle();
      end
      if (pend_q.size() != 0) begin
         $display("timeout while waiting for %0d outstanding responses", pend_q.size());
         errors++;
      end

      $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
